//--- verification/internal_system_stimulus.txt
# port(dec) op(0 read, 1 write) byte_addr wdata exp_rdata exp_exc, all hex except port
# exp_exc uses exception_o bit positions; only the issuing port's two bits are compared
0 0 00000100 00000000 a5a50040 0
1 0 00002000 00000000 a5a50800 0
0 1 00000104 11110001 00000000 0
1 1 00002004 5a5a1234 00000000 0
0 0 00000104 00000000 11110001 0
1 0 00002004 00000000 5a5a1234 0
0 1 00000200 beef0200 00000000 0
0 1 00000214 beef0214 00000000 0
0 1 00000228 beef0228 00000000 0
0 1 0000023c beef023c 00000000 0
1 1 00003ffc 77770fff 00000000 0
0 1 00000240 beef0240 00000000 0
0 1 00000254 beef0254 00000000 0
0 1 00000268 beef0268 00000000 0
0 1 0000027c beef027c 00000000 0
1 1 00002001 12345678 00000000 4
0 0 00000104 00000000 11110001 0
1 0 00008000 00000000 00000000 c
0 0 00000200 00000000 beef0200 0
0 0 00000102 00000000 00000000 1
0 0 00004000 00000000 00000000 3
0 0 00000108 00000000 a5a50042 3
1 0 00003ffc 00000000 77770fff c

//--- sources.f
+incdir+source
source/mem_sys_pkg.sv
source/cache_fa.sv
source/memory_controller_internal.sv
source/internal_system.sv
verification/internal_system_properties.sv
verification/internal_system_tb.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= internal_system_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- verification/internal_system_tb.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module internal_system_tb import mem_sys_pkg::*; ();

	localparam logic [`DATA_W-1:0] FILL_PATTERN = 32'hA5A5_0000;

	logic                    clock;
	logic                    rst_n;
	logic [3:0]              exception;
	logic                    core_req0, core_req1;
	mem_op_t                 core_op0, core_op1;
	logic [`CORE_ADDR_W-1:0] core_add0, core_add1;
	logic [`DATA_W-1:0]      core_wdata0, core_wdata1;
	logic                    core_ack0, core_ack1;
	logic [`DATA_W-1:0]      core_rdata0, core_rdata1;
	logic                    mem_req;
	mem_op_t                 mem_op;
	logic [`MEM_ADDR_W-1:0]  mem_add;
	logic [`DATA_W-1:0]      mem_wdata;
	logic [`DATA_W-1:0]      mem_rdata;
	logic                    mem_ack;

	// external word memory
	logic [`DATA_W-1:0] mem_model [`MEM_WORDS];

	// one entry per stimulus line
	int                      stim_port [$];
	logic                    stim_op [$];
	logic [`CORE_ADDR_W-1:0] stim_add [$];
	logic [`DATA_W-1:0]      stim_wdata [$];
	logic [`DATA_W-1:0]      stim_rdata [$];
	logic [3:0]              stim_exc [$];

	int errors = 0;
	int checks = 0;

	internal_system internal_system_i (
		.clock_i(clock), .rst_n_i(rst_n), .exception_o(exception),
		.core_req0_i(core_req0), .core_op0_i(core_op0), .core_add0_i(core_add0),
		.core_data0_i(core_wdata0), .core_ack0_o(core_ack0), .core_data0_o(core_rdata0),
		.core_req1_i(core_req1), .core_op1_i(core_op1), .core_add1_i(core_add1),
		.core_data1_i(core_wdata1), .core_ack1_o(core_ack1), .core_data1_o(core_rdata1),
		.mem_req_o(mem_req), .mem_op_o(mem_op), .mem_add_o(mem_add),
		.mem_data_o(mem_wdata), .mem_data_i(mem_rdata), .mem_ack_i(mem_ack)
	);

	always #10 clock = ~clock;

	// helpers
	// --------------------
	task automatic load_stimulus();
		int fd;
		int n;
		int port;
		logic [31:0] op, add, wdata, rdata, exc;
		string line;
		fd = $fopen("verification/internal_system_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// skip blank and comment lines
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %h %h %h %h %h", port, op, add, wdata, rdata, exc);
				if (n == 6 && (port == 0 || port == 1)) begin
					stim_port.push_back(port);
					stim_op.push_back(op[0]);
					stim_add.push_back(add);
					stim_wdata.push_back(wdata);
					stim_rdata.push_back(rdata);
					stim_exc.push_back(exc[3:0]);
				end else begin
					errors++;
					$display("malformed stimulus line: %s", line);
				end
			end
		end
		$fclose(fd);
		if (stim_port.size() == 0) begin
			errors++;
			$display("the stimulus file holds no transactions");
		end
	endtask

	// misaligned or beyond the external memory
	function automatic logic rejected(input logic [`CORE_ADDR_W-1:0] add);
		return (add[1:0] != 2'b00) || (add[`CORE_ADDR_W-1:2] >= 30'(`MEM_WORDS));
	endfunction

	// word index of a byte address
	function automatic int word_of(input logic [`CORE_ADDR_W-1:0] add);
		return int'(add[`CORE_ADDR_W-1:2]);
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, actual, expected);
		end
	endtask

	// an LRU cache drops a block once CACHE_BLOCKS other blocks were used after it
	// so the memory model must then hold the words written into it
	task automatic check_evicted_writes();
		int blk;
		int other;
		int addr_word;
		int newer [$];
		logic evicted;
		logic rewritten;
		logic known;
		for (int i = 0; i < stim_port.size(); i++) begin
			if (stim_op[i] && !rejected(stim_add[i])) begin
				addr_word = word_of(stim_add[i]);
				blk = addr_word / `BLOCK_WORDS;
				newer.delete();
				evicted = 1'b0;
				rewritten = 1'b0;
				for (int j = i + 1; j < stim_port.size(); j++) begin
					if (stim_port[j] == stim_port[i] && !rejected(stim_add[j])) begin
						other = word_of(stim_add[j]) / `BLOCK_WORDS;
						if (stim_op[j] && stim_add[j] == stim_add[i])
							rewritten = 1'b1;
						if (other == blk) begin
							newer.delete();
						end else begin
							known = 1'b0;
							foreach (newer[k]) begin
								if (newer[k] == other)
									known = 1'b1;
							end
							if (!known)
								newer.push_back(other);
							if (newer.size() >= `CACHE_BLOCKS_DEF)
								evicted = 1'b1;
						end
					end
				end
				if (evicted && !rewritten)
					check_value($sformatf("memory word %h after eviction", addr_word),
						mem_model[addr_word], stim_wdata[i]);
			end
		end
	endtask

	task automatic run_transaction(input int idx);
		int port;
		logic ack;
		logic [`DATA_W-1:0] rdata;
		logic [3:0] mask;
		logic [3:0] exc;
		port = stim_port[idx];
		mask = (port == 0) ? 4'b0011 : 4'b1100;
		if (port == 0) begin
			core_op0 = stim_op[idx] ? MEM_WRITE : MEM_READ;
			core_add0 = stim_add[idx];
			core_wdata0 = stim_wdata[idx];
			core_req0 = 1'b1;
		end else begin
			core_op1 = stim_op[idx] ? MEM_WRITE : MEM_READ;
			core_add1 = stim_add[idx];
			core_wdata1 = stim_wdata[idx];
			core_req1 = 1'b1;
		end
		do begin
			@(posedge clock);
			#2;
			ack = (port == 0) ? core_ack0 : core_ack1;
		end while (!ack);
		rdata = (port == 0) ? core_rdata0 : core_rdata1;
		exc = exception & mask;
		if (port == 0)
			core_req0 = 1'b0;
		else
			core_req1 = 1'b0;
		// ack must fall before the next request
		do begin
			@(posedge clock);
			#2;
			ack = (port == 0) ? core_ack0 : core_ack1;
		end while (ack);
		if (!stim_op[idx] || rejected(stim_add[idx]))
			check_value($sformatf("port %0d entry %0d read data", port, idx),
				rdata, stim_rdata[idx]);
		check_value($sformatf("port %0d entry %0d exception bits", port, idx),
			{28'b0, exc}, {28'b0, stim_exc[idx] & mask});
	endtask

	task automatic run_port_sequence(input int port);
		for (int i = 0; i < stim_port.size(); i++) begin
			if (stim_port[i] == port)
				run_transaction(i);
		end
	endtask

	// external memory model
	// --------------------
	initial begin : ext_memory
		integer seed;
		int delay;
		int a;
		seed = 97;
		mem_ack = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < `MEM_WORDS; i++)
			mem_model[i] = FILL_PATTERN ^ i;
		forever begin
			@(posedge clock);
			#2;
			if (mem_req && !mem_ack) begin
				delay = {$random(seed)} % 6;
				if (delay > 0) begin
					repeat (delay) @(posedge clock);
					#2;
				end
				a = int'(mem_add);
				if (a >= `MEM_WORDS) begin
					errors++;
					$display("external access outside the memory at word %h", mem_add);
				end else if (mem_op == MEM_WRITE) begin
					mem_model[a] = mem_wdata;
				end else begin
					mem_rdata = mem_model[a];
				end
				mem_ack = 1'b1;
				do begin
					@(posedge clock);
					#2;
				end while (mem_req);
				mem_ack = 1'b0;
			end
		end
	end

	// main sequence
	// --------------------
	initial begin
		logic [3:0] final_exc;
		clock = 1'b0;
		rst_n = 1'b0;
		core_req0 = 1'b0;
		core_req1 = 1'b0;
		core_op0 = MEM_READ;
		core_op1 = MEM_READ;
		core_add0 = '0;
		core_add1 = '0;
		core_wdata0 = '0;
		core_wdata1 = '0;
		load_stimulus();
		repeat (4) @(posedge clock);
		#2;
		rst_n = 1'b1;
		fork
			run_port_sequence(0);
			run_port_sequence(1);
		join
		check_evicted_writes();
		// every bit named by a rejection is still set
		final_exc = '0;
		foreach (stim_exc[i])
			final_exc |= stim_exc[i];
		check_value("final exception_o", {28'b0, exception}, {28'b0, final_exc});
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// watchdog
	initial begin
		int limit;
		#1;
		limit = stim_port.size() * 200 + 100;
		repeat (limit) @(posedge clock);
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- verification/internal_system_properties.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module internal_system_properties (
	input logic                    clock_i,
	input logic                    rst_n_i,
	input logic [3:0]              exception_i,
	input logic                    req0_i,
	input logic                    ack0_i,
	input logic                    op0_i,
	input logic [`CORE_ADDR_W-1:0] add0_i,
	input logic                    req1_i,
	input logic                    ack1_i,
	input logic                    op1_i,
	input logic [`CORE_ADDR_W-1:0] add1_i,
	input logic                    mem_req_i,
	input logic                    mem_ack_i
);

	// four-phase rules
	// --------------------
	ack0_has_req: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$rose(ack0_i) |-> req0_i || $past(req0_i))
		else $error("port 0 ack rose with no request");
	ack1_has_req: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$rose(ack1_i) |-> req1_i || $past(req1_i))
		else $error("port 1 ack rose with no request");
	mem_ack_has_req: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		$rose(mem_ack_i) |-> mem_req_i || $past(mem_req_i))
		else $error("external ack rose with no request");

	// request fields frozen while waiting
	req0_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req0_i && !ack0_i |=> ack0_i || (req0_i && $stable(op0_i) && $stable(add0_i)))
		else $error("port 0 request changed before its ack");
	req1_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		req1_i && !ack1_i |=> ack1_i || (req1_i && $stable(op1_i) && $stable(add1_i)))
		else $error("port 1 request changed before its ack");
	mem_req_held: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		mem_req_i && !mem_ack_i |=> mem_req_i)
		else $error("external request dropped before its ack");

	// sticky exception bits
	exc_sticky: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(exception_i & $past(exception_i)) == $past(exception_i))
		else $error("an exception bit cleared outside reset");

endmodule

bind internal_system internal_system_properties props_i (
	.clock_i(clock_i), .rst_n_i(rst_n_i), .exception_i(exception_o),
	.req0_i(core_req0_i), .ack0_i(core_ack0_o), .op0_i(core_op0_i), .add0_i(core_add0_i),
	.req1_i(core_req1_i), .ack1_i(core_ack1_o), .op1_i(core_op1_i), .add1_i(core_add1_i),
	.mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i)
);

//--- source/internal_system.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module internal_system import mem_sys_pkg::*; (
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	output logic [3:0]              exception_o,

	// port 0 instruction, port 1 data
	input  logic                    core_req0_i, core_req1_i,
	input  mem_op_t                 core_op0_i, core_op1_i,
	input  logic [`CORE_ADDR_W-1:0] core_add0_i, core_add1_i,
	input  logic [`DATA_W-1:0]      core_data0_i, core_data1_i,
	output logic                    core_ack0_o, core_ack1_o,
	output logic [`DATA_W-1:0]      core_data0_o, core_data1_o,

	// external word memory
	output logic                    mem_req_o,
	output mem_op_t                 mem_op_o,
	output logic [`MEM_ADDR_W-1:0]  mem_add_o,
	output logic [`DATA_W-1:0]      mem_data_o,
	input  logic [`DATA_W-1:0]      mem_data_i,
	input  logic                    mem_ack_i
);

	// controller <-> instruction cache
	logic                   cache0_req, cache0_ack, cache0_mem_req, cache0_mem_ack;
	mem_op_t                cache0_op, cache0_mem_op;
	logic [`MEM_ADDR_W-1:0] cache0_add, cache0_mem_add;
	logic [`DATA_W-1:0]     cache0_wdata, cache0_rdata, cache0_mem_wdata, cache0_mem_rdata;

	// controller <-> data cache
	logic                   cache1_req, cache1_ack, cache1_mem_req, cache1_mem_ack;
	mem_op_t                cache1_op, cache1_mem_op;
	logic [`MEM_ADDR_W-1:0] cache1_add, cache1_mem_add;
	logic [`DATA_W-1:0]     cache1_wdata, cache1_rdata, cache1_mem_wdata, cache1_mem_rdata;

	memory_controller_internal mem_cont_int (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .exception_o(exception_o),
		.core_req0_i(core_req0_i), .core_op0_i(core_op0_i), .core_add0_i(core_add0_i),
		.core_data0_i(core_data0_i), .core_ack0_o(core_ack0_o), .core_data0_o(core_data0_o),
		.core_req1_i(core_req1_i), .core_op1_i(core_op1_i), .core_add1_i(core_add1_i),
		.core_data1_i(core_data1_i), .core_ack1_o(core_ack1_o), .core_data1_o(core_data1_o),
		.cache0_req_o(cache0_req), .cache0_op_o(cache0_op), .cache0_add_o(cache0_add),
		.cache0_data_o(cache0_wdata), .cache0_ack_i(cache0_ack), .cache0_data_i(cache0_rdata),
		.cache1_req_o(cache1_req), .cache1_op_o(cache1_op), .cache1_add_o(cache1_add),
		.cache1_data_o(cache1_wdata), .cache1_ack_i(cache1_ack), .cache1_data_i(cache1_rdata),
		.cache0_mem_req_i(cache0_mem_req), .cache0_mem_op_i(cache0_mem_op),
		.cache0_mem_add_i(cache0_mem_add), .cache0_mem_data_i(cache0_mem_wdata),
		.cache0_mem_ack_o(cache0_mem_ack), .cache0_mem_data_o(cache0_mem_rdata),
		.cache1_mem_req_i(cache1_mem_req), .cache1_mem_op_i(cache1_mem_op),
		.cache1_mem_add_i(cache1_mem_add), .cache1_mem_data_i(cache1_mem_wdata),
		.cache1_mem_ack_o(cache1_mem_ack), .cache1_mem_data_o(cache1_mem_rdata),
		.mem_req_o(mem_req_o), .mem_op_o(mem_op_o), .mem_add_o(mem_add_o),
		.mem_data_o(mem_data_o), .mem_data_i(mem_data_i), .mem_ack_i(mem_ack_i)
	);

	cache_fa inst_cache (
		.clock_i(clock_i), .rst_n_i(rst_n_i),
		.req_i(cache0_req), .op_i(cache0_op), .add_i(cache0_add), .data_i(cache0_wdata),
		.ack_o(cache0_ack), .data_o(cache0_rdata),
		.mem_req_o(cache0_mem_req), .mem_op_o(cache0_mem_op), .mem_add_o(cache0_mem_add),
		.mem_data_o(cache0_mem_wdata), .mem_data_i(cache0_mem_rdata), .mem_ack_i(cache0_mem_ack)
	);

	cache_fa data_cache (
		.clock_i(clock_i), .rst_n_i(rst_n_i),
		.req_i(cache1_req), .op_i(cache1_op), .add_i(cache1_add), .data_i(cache1_wdata),
		.ack_o(cache1_ack), .data_o(cache1_rdata),
		.mem_req_o(cache1_mem_req), .mem_op_o(cache1_mem_op), .mem_add_o(cache1_mem_add),
		.mem_data_o(cache1_mem_wdata), .mem_data_i(cache1_mem_rdata), .mem_ack_i(cache1_mem_ack)
	);

endmodule

//--- source/memory_controller_internal.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module memory_controller_internal import mem_sys_pkg::*; (
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	output logic [3:0]              exception_o,

	// core ports, byte addressed
	input  logic                    core_req0_i, core_req1_i,
	input  mem_op_t                 core_op0_i, core_op1_i,
	input  logic [`CORE_ADDR_W-1:0] core_add0_i, core_add1_i,
	input  logic [`DATA_W-1:0]      core_data0_i, core_data1_i,
	output logic                    core_ack0_o, core_ack1_o,
	output logic [`DATA_W-1:0]      core_data0_o, core_data1_o,

	// toward the caches, word addressed
	output logic                    cache0_req_o, cache1_req_o,
	output mem_op_t                 cache0_op_o, cache1_op_o,
	output logic [`MEM_ADDR_W-1:0]  cache0_add_o, cache1_add_o,
	output logic [`DATA_W-1:0]      cache0_data_o, cache1_data_o,
	input  logic                    cache0_ack_i, cache1_ack_i,
	input  logic [`DATA_W-1:0]      cache0_data_i, cache1_data_i,

	// cache miss requests
	input  logic                    cache0_mem_req_i, cache1_mem_req_i,
	input  mem_op_t                 cache0_mem_op_i, cache1_mem_op_i,
	input  logic [`MEM_ADDR_W-1:0]  cache0_mem_add_i, cache1_mem_add_i,
	input  logic [`DATA_W-1:0]      cache0_mem_data_i, cache1_mem_data_i,
	output logic                    cache0_mem_ack_o, cache1_mem_ack_o,
	output logic [`DATA_W-1:0]      cache0_mem_data_o, cache1_mem_data_o,

	// external memory
	output logic                    mem_req_o,
	output mem_op_t                 mem_op_o,
	output logic [`MEM_ADDR_W-1:0]  mem_add_o,
	output logic [`DATA_W-1:0]      mem_data_o,
	input  logic [`DATA_W-1:0]      mem_data_i,
	input  logic                    mem_ack_i
);

	// per-port stage
	// --------------------
	wire [1:0]                   core_req = {core_req1_i, core_req0_i};
	wire [1:0]                   core_op = {core_op1_i, core_op0_i};
	wire [1:0][`CORE_ADDR_W-1:0] core_add = {core_add1_i, core_add0_i};
	wire [1:0][`DATA_W-1:0]      core_wdata = {core_data1_i, core_data0_i};
	wire [1:0]                   cache_ack = {cache1_ack_i, cache0_ack_i};
	wire [1:0][`DATA_W-1:0]      cache_rdata = {cache1_data_i, cache0_data_i};

	logic [1:0]                  core_ack;
	logic [1:0][`DATA_W-1:0]     core_rdata;
	logic [1:0]                  fwd_req;
	mem_op_t                     fwd_op [2];
	logic [1:0][`MEM_ADDR_W-1:0] fwd_add;
	logic [1:0][`DATA_W-1:0]     fwd_data;

	for (genvar n = 0; n < 2; n++) begin : g_port
		logic                    req_q;
		mem_op_t                 op_q;
		logic [`CORE_ADDR_W-1:0] add_q;
		logic [`DATA_W-1:0]      wdata_q;
		logic                    ack_q;
		logic [`DATA_W-1:0]      rdata_q;
		logic [1:0]              exc_q;
		logic                    misaligned;
		logic                    out_of_range;

		assign misaligned = |add_q[1:0];
		assign out_of_range = add_q[`CORE_ADDR_W-1:2] >= (`CORE_ADDR_W-2)'(`MEM_WORDS);

		always_ff @(posedge clock_i) begin
			if (!rst_n_i) begin
				req_q <= 1'b0;
				ack_q <= 1'b0;
				exc_q <= 2'b00;
			end else begin
				req_q <= core_req[n];
				// rejected requests are answered here, never reach the cache
				ack_q <= cache_ack[n] | (req_q & (misaligned | out_of_range));
				if (req_q && misaligned)
					exc_q[0] <= 1'b1;
				if (req_q && !misaligned && out_of_range)
					exc_q[1] <= 1'b1;
			end
		end

		always_ff @(posedge clock_i) begin
			op_q <= mem_op_t'(core_op[n]);
			add_q <= core_add[n];
			wdata_q <= core_wdata[n];
			rdata_q <= cache_ack[n] ? cache_rdata[n] : '0;
		end

		assign fwd_req[n] = req_q & ~misaligned & ~out_of_range;
		assign fwd_op[n] = op_q;
		assign fwd_add[n] = add_q[`MEM_ADDR_W+1:2];
		assign fwd_data[n] = wdata_q;
		assign core_ack[n] = ack_q;
		assign core_rdata[n] = rdata_q;
		assign exception_o[2*n +: 2] = exc_q;
	end

	assign {core_ack1_o, core_ack0_o} = core_ack;
	assign {core_data1_o, core_data0_o} = core_rdata;
	assign {cache1_req_o, cache0_req_o} = fwd_req;
	assign {cache1_add_o, cache0_add_o} = fwd_add;
	assign {cache1_data_o, cache0_data_o} = fwd_data;
	assign cache0_op_o = fwd_op[0];
	assign cache1_op_o = fwd_op[1];

	// external bus arbiter
	// --------------------
	arb_state_t arb_q;
	logic       last_q;
	logic       gnt0;
	logic       gnt1;

	// last_q high means cache 1 owned the bus last, so cache 0 goes first after reset
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			arb_q <= ARB_IDLE;
			last_q <= 1'b1;
		end else begin
			unique case (arb_q)
				ARB_IDLE: begin
					if (cache0_mem_req_i && (last_q || !cache1_mem_req_i)) begin
						arb_q <= ARB_CACHE0;
						last_q <= 1'b0;
					end else if (cache1_mem_req_i) begin
						arb_q <= ARB_CACHE1;
						last_q <= 1'b1;
					end
				end
				// hold the grant until the whole handshake has returned to zero
				ARB_CACHE0: begin
					if (!cache0_mem_req_i && !mem_ack_i)
						arb_q <= ARB_IDLE;
				end
				ARB_CACHE1: begin
					if (!cache1_mem_req_i && !mem_ack_i)
						arb_q <= ARB_IDLE;
				end
				default: arb_q <= ARB_IDLE;
			endcase
		end
	end

	assign gnt0 = (arb_q == ARB_CACHE0);
	assign gnt1 = (arb_q == ARB_CACHE1);

	assign mem_req_o = (gnt0 & cache0_mem_req_i) | (gnt1 & cache1_mem_req_i);
	assign mem_op_o = gnt1 ? cache1_mem_op_i : cache0_mem_op_i;
	assign mem_add_o = gnt1 ? cache1_mem_add_i : cache0_mem_add_i;
	assign mem_data_o = gnt1 ? cache1_mem_data_i : cache0_mem_data_i;
	assign cache0_mem_ack_o = gnt0 & mem_ack_i;
	assign cache1_mem_ack_o = gnt1 & mem_ack_i;
	assign cache0_mem_data_o = mem_data_i;
	assign cache1_mem_data_o = mem_data_i;

endmodule

//--- source/cache_fa.sv
`timescale 1ns/1ps
`include "mem_sys_consts.svh"

module cache_fa import mem_sys_pkg::*; #(
	parameter int CACHE_BLOCKS = `CACHE_BLOCKS_DEF
) (
	input  logic                   clock_i,
	input  logic                   rst_n_i,

	// core side, word addressed
	input  logic                   req_i,
	input  mem_op_t                op_i,
	input  logic [`MEM_ADDR_W-1:0] add_i,
	input  logic [`DATA_W-1:0]     data_i,
	output logic                   ack_o,
	output logic [`DATA_W-1:0]     data_o,

	// miss side toward the external memory
	output logic                   mem_req_o,
	output mem_op_t                mem_op_o,
	output logic [`MEM_ADDR_W-1:0] mem_add_o,
	output logic [`DATA_W-1:0]     mem_data_o,
	input  logic [`DATA_W-1:0]     mem_data_i,
	input  logic                   mem_ack_i
);

	localparam int IDX_W = $clog2(CACHE_BLOCKS);
	localparam int OFF_W = $clog2(`BLOCK_WORDS);
	localparam int TAG_W = `MEM_ADDR_W - OFF_W;

	// line storage
	// --------------------
	logic [TAG_W-1:0]        tag_q  [CACHE_BLOCKS];
	logic [`DATA_W-1:0]      data_q [CACHE_BLOCKS][`BLOCK_WORDS];
	logic [IDX_W-1:0]        age_q  [CACHE_BLOCKS];
	logic [CACHE_BLOCKS-1:0] valid_q;
	logic [CACHE_BLOCKS-1:0] dirty_q;

	// sequencer
	cache_state_t       state_q;
	logic [IDX_W-1:0]   line_q;
	logic [OFF_W:0]     cnt_q;
	logic               mem_req_q;
	logic               ack_q;
	logic [`DATA_W-1:0] rdata_q;

	logic [TAG_W-1:0]   req_tag;
	logic [OFF_W-1:0]   req_off;
	logic [OFF_W-1:0]   word;
	logic               blk_done;
	logic               hit;
	logic [IDX_W-1:0]   hit_idx;
	logic [IDX_W-1:0]   victim_idx;

	assign req_tag = add_i[`MEM_ADDR_W-1:OFF_W];
	assign req_off = add_i[OFF_W-1:0];
	assign word = cnt_q[OFF_W-1:0];
	assign blk_done = (cnt_q == (OFF_W+1)'(`BLOCK_WORDS));

	// tag match over all lines
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < CACHE_BLOCKS; i++) begin
			if (valid_q[i] && tag_q[i] == req_tag) begin
				hit = 1'b1;
				hit_idx = IDX_W'(i);
			end
		end
	end

	// oldest line, unless a free one exists
	always_comb begin
		victim_idx = '0;
		for (int i = 0; i < CACHE_BLOCKS; i++) begin
			if (age_q[i] == IDX_W'(CACHE_BLOCKS - 1))
				victim_idx = IDX_W'(i);
		end
		for (int i = CACHE_BLOCKS - 1; i >= 0; i--) begin
			if (!valid_q[i])
				victim_idx = IDX_W'(i);
		end
	end

	// control
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			ack_q <= 1'b0;
			mem_req_q <= 1'b0;
			cnt_q <= '0;
			valid_q <= '0;
			dirty_q <= '0;
			// ages start as a permutation and stay one
			for (int i = 0; i < CACHE_BLOCKS; i++)
				age_q[i] <= IDX_W'(i);
		end else begin
			unique case (state_q)
				IDLE: begin
					if (req_i)
						state_q <= LOOKUP;
				end
				LOOKUP: begin
					cnt_q <= '0;
					if (hit)
						state_q <= RESPOND;
					else if (valid_q[victim_idx] && dirty_q[victim_idx])
						state_q <= WRITEBACK;
					else
						state_q <= REFILL;
				end
				WRITEBACK, REFILL: begin
					// one four-phase transfer per word
					if (mem_req_q && mem_ack_i) begin
						mem_req_q <= 1'b0;
						cnt_q <= cnt_q + 1'b1;
					end else if (!mem_req_q && !mem_ack_i) begin
						if (!blk_done) begin
							mem_req_q <= 1'b1;
						end else if (state_q == WRITEBACK) begin
							cnt_q <= '0;
							state_q <= REFILL;
						end else begin
							cnt_q <= '0;
							valid_q[line_q] <= 1'b1;
							dirty_q[line_q] <= 1'b0;
							state_q <= RESPOND;
						end
					end
				end
				RESPOND: begin
					if (op_i == MEM_WRITE)
						dirty_q[line_q] <= 1'b1;
					for (int i = 0; i < CACHE_BLOCKS; i++) begin
						if (age_q[i] < age_q[line_q])
							age_q[i] <= age_q[i] + 1'b1;
					end
					age_q[line_q] <= '0;
					ack_q <= 1'b1;
					state_q <= RELEASE;
				end
				RELEASE: begin
					if (!req_i) begin
						ack_q <= 1'b0;
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// datapath
	// --------------------
	always_ff @(posedge clock_i) begin
		if (state_q == LOOKUP)
			line_q <= hit ? hit_idx : victim_idx;
		if (state_q == REFILL && mem_req_q && mem_ack_i)
			data_q[line_q][word] <= mem_data_i;
		if (state_q == REFILL && !mem_req_q && !mem_ack_i && blk_done)
			tag_q[line_q] <= req_tag;
		if (state_q == RESPOND) begin
			if (op_i == MEM_WRITE)
				data_q[line_q][req_off] <= data_i;
			else
				rdata_q <= data_q[line_q][req_off];
		end
	end

	// write-back uses the victim's tag, refill the requested one
	assign mem_req_o = mem_req_q;
	assign mem_op_o = (state_q == WRITEBACK) ? MEM_WRITE : MEM_READ;
	assign mem_add_o = {(state_q == WRITEBACK) ? tag_q[line_q] : req_tag, word};
	assign mem_data_o = data_q[line_q][word];

	assign ack_o = ack_q;
	assign data_o = rdata_q;

endmodule

//--- source/mem_sys_pkg.sv
package mem_sys_pkg;

	// direction of a transfer on any link
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_t;

	// cache sequencer
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		RESPOND,
		RELEASE
	} cache_state_t;

	// owner of the external memory bus
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CACHE0,
		ARB_CACHE1
	} arb_state_t;

endpackage

//--- source/mem_sys_consts.svh
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

// bus widths
// --------------------
`define CORE_ADDR_W 32
`define MEM_ADDR_W 24
`define DATA_W 32

// cache geometry
// --------------------
`define BLOCK_WORDS 4

// capacity in blocks when the instance sets none
`define CACHE_BLOCKS_DEF 8

// external memory
// --------------------
// size in words
// any core access at or above it raises a range exception
`define MEM_WORDS 4096

`endif
